//--- bits_estimator.sv
`timescale 1ns/1ps
`default_nettype none
`include "datapath_defines.svh"

module bits_estimator
    import datapath_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire dsp_cfg_t   cfg_i,
    input  wire code_word_t codes_i,
    output bit_word_t       bits_o,
    output code_word_t      codes_o
);

    localparam int PROD_W = `DP_WEIGHT_W + `DP_CODE_W;
    localparam int HIST   = `DP_FFE_TAPS - 1;

    typedef logic signed [PROD_W-1:0]    prod_t;
    typedef logic signed [`DP_EST_W-1:0] est_t;

    // previous word, doubles as first delay of the code pass-through
    code_word_t codes_q;

    // tail of the previous word followed by the current word
    code_t [`DP_LANES+HIST-1:0] code_win;

    prod_t [`DP_FFE_TAPS-1:0] prod_q [`DP_LANES];
    est_t est [`DP_LANES];

    assign code_win = {codes_i, codes_q[`DP_LANES-1 -: HIST]};

    // first stage: one product per lane and tap
    always_ff @(posedge clk) begin
        if (reset_i) begin
            codes_q <= '0;
            for (int l = 0; l < `DP_LANES; l++) begin
                prod_q[l] <= '0;
            end
        end else begin
            codes_q <= codes_i;
            for (int l = 0; l < `DP_LANES; l++) begin
                for (int k = 0; k < `DP_FFE_TAPS; k++) begin
                    // tap k reaches k symbols back
                    prod_q[l][k] <= $signed(cfg_i.ffe_weights[k]) *
                                    $signed(code_win[l + HIST - k]);
                end
            end
        end
    end

    // sum and scale the products
    always_comb begin
        for (int l = 0; l < `DP_LANES; l++) begin
            est[l] = '0;
            for (int k = 0; k < `DP_FFE_TAPS; k++) begin
                est[l] = est[l] + $signed(prod_q[l][k]);
            end
            est[l] = est[l] >>> cfg_i.ffe_shift;
        end
    end

    // second stage: slice at zero, keep codes in step
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bits_o  <= '0;
            codes_o <= '0;
        end else begin
            for (int l = 0; l < `DP_LANES; l++) begin
                bits_o[l] <= ~est[l][`DP_EST_W-1];
            end
            codes_o <= codes_q;
        end
    end

endmodule

`default_nettype wire

//--- datapath_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "datapath_defines.svh"

module datapath_core
    import datapath_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire dsp_cfg_t   cfg_i,
    input  wire code_word_t adc_codes_i,
    output bit_word_t       sd_flags_o,
    output bit_word_t       sliced_bits_o,
    output res_word_t       res_errors_o,
    output bit_word_t       aligned_sliced_bits_o
);

    bit_word_t  est_bits;
    code_word_t est_codes;
    slice_res_t res_stage;
    slice_res_t chk_stage;
    bit_word_t  chk_flags;
    slice_res_t corr_stage;

    assign sd_flags_o    = chk_flags;
    assign sliced_bits_o = corr_stage.bits;
    assign res_errors_o  = corr_stage.res;

    bits_estimator bits_est_i (
        .clk     (clk),
        .reset_i (reset_i),
        .cfg_i   (cfg_i),
        .codes_i (adc_codes_i),
        .bits_o  (est_bits),
        .codes_o (est_codes)
    );

    res_err_estimator res_err_i (
        .clk     (clk),
        .reset_i (reset_i),
        .cfg_i   (cfg_i),
        .bits_i  (est_bits),
        .codes_i (est_codes),
        .stage_o (res_stage)
    );

    error_checker err_chk_i (
        .clk     (clk),
        .reset_i (reset_i),
        .cfg_i   (cfg_i),
        .stage_i (res_stage),
        .stage_o (chk_stage),
        .flags_o (chk_flags)
    );

    error_corrector err_corr_i (
        .clk     (clk),
        .reset_i (reset_i),
        .cfg_i   (cfg_i),
        .stage_i (chk_stage),
        .flags_i (chk_flags),
        .stage_o (corr_stage)
    );

    // uncorrected bits, lined up with the corrector output
    stage_align_buffer #(
        .DEPTH (`DP_ALIGN_DEPTH)
    ) align_i (
        .clk     (clk),
        .reset_i (reset_i),
        .bits_i  (res_stage.bits),
        .bits_o  (aligned_sliced_bits_o)
    );

endmodule

`default_nettype wire

//--- datapath_defines.svh
`ifndef DATAPATH_DEFINES_SVH
`define DATAPATH_DEFINES_SVH

// symbols per word, lane 0 is the earliest
`define DP_LANES 4

// signed adc code
`define DP_CODE_W 8

// ffe weights and tap count
`define DP_WEIGHT_W 8
`define DP_FFE_TAPS 3
`define DP_SHIFT_W 4

// ffe accumulator, holds three full products
`define DP_EST_W 18

// channel estimate, tap 0 is the main cursor
`define DP_CHAN_TAPS 3
`define DP_CHAN_W 8

// residual error and window energy
`define DP_RES_W 12
`define DP_ENER_W 24

// residual stage output to corrector output, in cycles
`define DP_ALIGN_DEPTH 3

`endif

//--- datapath_pkg.sv
`default_nettype none
`include "datapath_defines.svh"

package datapath_pkg;

    // single lane values
    typedef logic signed [`DP_CODE_W-1:0]   code_t;
    typedef logic signed [`DP_RES_W-1:0]    res_t;
    typedef logic signed [`DP_WEIGHT_W-1:0] weight_t;
    typedef logic signed [`DP_CHAN_W-1:0]   chan_tap_t;

    // one word of adc codes
    typedef code_t [`DP_LANES-1:0] code_word_t;

    // sliced bits, 1 means +1 and 0 means -1
    typedef logic [`DP_LANES-1:0] bit_word_t;

    // one word of residual errors
    typedef res_t [`DP_LANES-1:0] res_word_t;

    // bits and residuals move together between the stages
    typedef struct packed {
        bit_word_t bits;
        res_word_t res;
    } slice_res_t;

    // static configuration, common to every lane
    typedef struct packed {
        weight_t [`DP_FFE_TAPS-1:0]    ffe_weights;
        logic    [`DP_SHIFT_W-1:0]     ffe_shift;
        chan_tap_t [`DP_CHAN_TAPS-1:0] channel_est;
    } dsp_cfg_t;

endpackage

`default_nettype wire

//--- error_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "datapath_defines.svh"

module error_checker
    import datapath_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire dsp_cfg_t   cfg_i,
    input  wire slice_res_t stage_i,
    output slice_res_t      stage_o,
    output bit_word_t       flags_o
);

    localparam int HIST   = `DP_CHAN_TAPS - 1;
    localparam int TERM_W = `DP_CHAN_W + 2;
    localparam int PERT_W = `DP_RES_W + 1;

    // residuals out of the estimator stay near +-512, so the square fits
    function automatic logic [`DP_ENER_W-1:0] square(input logic signed [PERT_W-1:0] x);
        logic signed [2*PERT_W-1:0] p;
        p = x * x;
        return p[`DP_ENER_W-1:0];
    endfunction

    // word under test, flags wait for the next word
    slice_res_t held_q;

    res_t [`DP_LANES+HIST-1:0] res_win;

    logic signed [TERM_W-1:0] twice_h [`DP_CHAN_TAPS];
    logic signed [TERM_W-1:0] term;
    logic signed [PERT_W-1:0] pert;
    logic [`DP_ENER_W-1:0] ener0 [`DP_LANES];
    logic [`DP_ENER_W-1:0] ener1 [`DP_LANES];
    bit_word_t flags;

    // window spills into the first lanes of the next word
    assign res_win = {stage_i.res[HIST-1:0], held_q.res};

    always_comb begin
        for (int k = 0; k < `DP_CHAN_TAPS; k++) begin
            twice_h[k] = {cfg_i.channel_est[k][`DP_CHAN_W-1], cfg_i.channel_est[k], 1'b0};
        end
    end

    always_comb begin
        term = '0;
        pert = '0;
        for (int m = 0; m < `DP_LANES; m++) begin
            ener0[m] = '0;
            ener1[m] = '0;
            for (int k = 0; k < `DP_CHAN_TAPS; k++) begin
                // flipping s[m] moves its response from -h*s to +h*s
                term = held_q.bits[m] ? twice_h[k] : -twice_h[k];
                pert = res_win[m+k] + term;
                ener0[m] = ener0[m] + square(res_win[m+k]);
                ener1[m] = ener1[m] + square(pert);
            end
            flags[m] = (ener1[m] < ener0[m]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            held_q  <= '0;
            stage_o <= '0;
            flags_o <= '0;
        end else begin
            held_q  <= stage_i;
            stage_o <= held_q;
            flags_o <= flags;
        end
    end

endmodule

`default_nettype wire

//--- error_corrector.sv
`timescale 1ns/1ps
`default_nettype none
`include "datapath_defines.svh"

module error_corrector
    import datapath_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire dsp_cfg_t   cfg_i,
    input  wire slice_res_t stage_i,
    input  wire bit_word_t  flags_i,
    output slice_res_t      stage_o
);

    localparam int HIST   = `DP_CHAN_TAPS - 1;
    localparam int TERM_W = `DP_CHAN_W + 2;

    // corrections owed to the first lanes of the next word
    res_t [HIST-1:0] carry_q;

    res_t [`DP_LANES+HIST-1:0] corr;
    logic signed [TERM_W-1:0] twice_h [`DP_CHAN_TAPS];
    slice_res_t corrected;

    always_comb begin
        for (int k = 0; k < `DP_CHAN_TAPS; k++) begin
            twice_h[k] = {cfg_i.channel_est[k][`DP_CHAN_W-1], cfg_i.channel_est[k], 1'b0};
        end
    end

    always_comb begin
        corr = '0;
        corr[HIST-1:0] = carry_q;
        // each flag adds 2*h_k*s_old over its three symbols
        for (int m = 0; m < `DP_LANES; m++) begin
            if (flags_i[m]) begin
                for (int k = 0; k < `DP_CHAN_TAPS; k++) begin
                    corr[m+k] = corr[m+k] + (stage_i.bits[m] ? twice_h[k] : -twice_h[k]);
                end
            end
        end
        corrected.bits = stage_i.bits ^ flags_i;
        for (int l = 0; l < `DP_LANES; l++) begin
            corrected.res[l] = $signed(stage_i.res[l]) + $signed(corr[l]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            stage_o <= '0;
            carry_q <= '0;
        end else begin
            stage_o <= corrected;
            // positions past lane 3 roll over
            carry_q <= corr[`DP_LANES+HIST-1:`DP_LANES];
        end
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
datapath_pkg.sv
bits_estimator.sv
res_err_estimator.sv
error_checker.sv
error_corrector.sv
stage_align_buffer.sv
datapath_core.sv
tb_datapath_core.sv

//--- res_err_estimator.sv
`timescale 1ns/1ps
`default_nettype none
`include "datapath_defines.svh"

module res_err_estimator
    import datapath_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire dsp_cfg_t   cfg_i,
    input  wire bit_word_t  bits_i,
    input  wire code_word_t codes_i,
    output slice_res_t      stage_o
);

    localparam int HIST   = `DP_CHAN_TAPS - 1;
    // three taps of +-h need two bits of growth
    localparam int RESP_W = `DP_CHAN_W + 2;

    typedef logic signed [RESP_W-1:0] resp_t;

    // bit history for the post-cursors, also the bit delay
    bit_word_t  bits_q;
    code_word_t codes_q;

    logic [`DP_LANES+HIST-1:0] bit_win;
    resp_t resp   [`DP_LANES];
    resp_t resp_q [`DP_LANES];

    assign bit_win = {bits_i, bits_q[`DP_LANES-1 -: HIST]};

    // channel response of the sliced symbols
    always_comb begin
        for (int l = 0; l < `DP_LANES; l++) begin
            resp[l] = '0;
            for (int k = 0; k < `DP_CHAN_TAPS; k++) begin
                if (bit_win[l + HIST - k]) begin
                    resp[l] = resp[l] + $signed(cfg_i.channel_est[k]);
                end else begin
                    resp[l] = resp[l] - $signed(cfg_i.channel_est[k]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            bits_q  <= '0;
            codes_q <= '0;
            for (int l = 0; l < `DP_LANES; l++) begin
                resp_q[l] <= '0;
            end
        end else begin
            bits_q  <= bits_i;
            codes_q <= codes_i;
            for (int l = 0; l < `DP_LANES; l++) begin
                resp_q[l] <= resp[l];
            end
        end
    end

    // residual = code minus expected channel output
    always_ff @(posedge clk) begin
        if (reset_i) begin
            stage_o <= '0;
        end else begin
            stage_o.bits <= bits_q;
            for (int l = 0; l < `DP_LANES; l++) begin
                stage_o.res[l] <= $signed(codes_q[l]) - resp_q[l];
            end
        end
    end

endmodule

`default_nettype wire

//--- stage_align_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "datapath_defines.svh"

module stage_align_buffer
    import datapath_pkg::*;
#(
    parameter int DEPTH = `DP_ALIGN_DEPTH
) (
    input  wire logic      clk,
    input  wire logic      reset_i,
    input  wire bit_word_t bits_i,
    output bit_word_t      bits_o
);

    // entry 0 is the newest word
    bit_word_t [DEPTH-1:0] pipe_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pipe_q <= '0;
        end else begin
            pipe_q[0] <= bits_i;
            for (int i = 1; i < DEPTH; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
        end
    end

    assign bits_o = pipe_q[DEPTH-1];

endmodule

`default_nettype wire

//--- tb_datapath_model.svh
`ifndef TB_DATAPATH_MODEL_SVH
`define TB_DATAPATH_MODEL_SVH

localparam int N_PHASES = 3;
localparam int N_CHECK  = 200;
// trailing words give the last checked word its look-ahead
localparam int N_DRIVE  = N_CHECK + 8;
localparam int N_SYM    = N_DRIVE * `DP_LANES;
// two virtual words ahead of word 0
localparam int PRE      = 2 * `DP_LANES;
localparam logic [31:0] SEED = 32'd14049;

logic [31:0] lcg_state;
code_word_t  stim_codes [N_PHASES][N_DRIVE];
bit_word_t   exp_flag_w [N_PHASES][N_DRIVE];
bit_word_t   exp_raw_w  [N_PHASES][N_DRIVE];
bit_word_t   exp_bit_w  [N_PHASES][N_DRIVE];
res_word_t   exp_res_w  [N_PHASES][N_DRIVE];

function automatic code_t lcg_code();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return code_t'(lcg_state[23:16]);
endfunction

function automatic int sym_value(input logic b);
    return b ? 1 : -1;
endfunction

function automatic res_word_t widen_codes(input code_word_t c);
    res_word_t r;
    for (int l = 0; l < `DP_LANES; l++) begin
        r[l] = res_t'($signed(c[l]));
    end
    return r;
endfunction

// word -2 holds the slicer reset value (bits 0)
// word -1 is the slice of a zero estimate (bits 1) with zero codes
task automatic build_model(input int p, input dsp_cfg_t cfg);
    int   c  [PRE+N_SYM];
    logic b  [PRE+N_SYM];
    int   r  [PRE+N_SYM];
    logic f  [PRE+N_SYM];
    int   rc [PRE+N_SYM];
    int   w  [`DP_FFE_TAPS];
    int   h  [`DP_CHAN_TAPS];
    int   est;
    int   e0;
    int   e1;
    int   d;
    int   idx;
    for (int k = 0; k < `DP_FFE_TAPS; k++) begin
        w[k] = $signed(cfg.ffe_weights[k]);
    end
    for (int k = 0; k < `DP_CHAN_TAPS; k++) begin
        h[k] = $signed(cfg.channel_est[k]);
    end
    for (int q = 0; q < PRE + N_SYM; q++) begin
        c[q] = 0;
        if (q >= PRE) begin
            c[q] = $signed(stim_codes[p][(q-PRE)/`DP_LANES][(q-PRE)%`DP_LANES]);
        end
        b[q]  = 1'b0;
        f[q]  = 1'b0;
        r[q]  = 0;
        rc[q] = 0;
        if (q >= `DP_LANES) begin
            est = 0;
            for (int k = 0; k < `DP_FFE_TAPS; k++) begin
                est = est + w[k] * c[q-k];
            end
            est  = est >>> cfg.ffe_shift;
            b[q] = (est >= 0);
        end
    end
    for (int q = `DP_LANES; q < PRE + N_SYM; q++) begin
        r[q] = c[q];
        for (int k = 0; k < `DP_CHAN_TAPS; k++) begin
            r[q] = r[q] - h[k] * sym_value(b[q-k]);
        end
        rc[q] = r[q];
    end
    // every flag looks at uncorrected residuals only
    for (int q = `DP_LANES; q < PRE + N_SYM - 2; q++) begin
        e0 = 0;
        e1 = 0;
        for (int k = 0; k < `DP_CHAN_TAPS; k++) begin
            d  = r[q+k] + 2 * h[k] * sym_value(b[q]);
            e0 = e0 + r[q+k] * r[q+k];
            e1 = e1 + d * d;
        end
        f[q] = (e1 < e0);
    end
    for (int q = `DP_LANES; q < PRE + N_SYM - 2; q++) begin
        if (f[q]) begin
            for (int k = 0; k < `DP_CHAN_TAPS; k++) begin
                rc[q+k] = rc[q+k] + 2 * h[k] * sym_value(b[q]);
            end
        end
    end
    for (int i = 0; i < N_DRIVE; i++) begin
        for (int l = 0; l < `DP_LANES; l++) begin
            idx = PRE + i * `DP_LANES + l;
            exp_flag_w[p][i][l] = f[idx];
            exp_raw_w[p][i][l]  = b[idx];
            exp_bit_w[p][i][l]  = b[idx] ^ f[idx];
            exp_res_w[p][i][l]  = res_t'(rc[idx]);
        end
    end
endtask

`endif

//--- tb_datapath_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "datapath_defines.svh"

module tb_datapath_core
    import datapath_pkg::*;
();

    localparam int RST_CYC  = 4;
    // word driven at edge t shows on sd_flags_o after t+6, the rest after t+7
    localparam int FLAG_LAT = 6;
    localparam int OUT_LAT  = 7;

    logic       clk = 1'b0;
    logic       reset_i;
    dsp_cfg_t   cfg_i;
    code_word_t adc_codes_i;
    bit_word_t  sd_flags_o;
    bit_word_t  sliced_bits_o;
    res_word_t  res_errors_o;
    bit_word_t  aligned_sliced_bits_o;

    int drv_idx;
    int ph;
    int fail_cnt;

    `include "tb_datapath_model.svh"

    localparam int TIMEOUT_CYC = N_PHASES * (RST_CYC + N_DRIVE) + 64;

    dsp_cfg_t  phase_cfg [N_PHASES];
    int        cyc_cnt  = 0;
    logic      reset_d  = 1'b0;
    logic      flag_en  = 1'b0;
    logic      out_en   = 1'b0;
    bit_word_t flags_d  = '0;
    bit_word_t exp_flags   = '0;
    bit_word_t exp_bits    = '0;
    bit_word_t exp_aligned = '0;
    res_word_t exp_res     = '0;
    res_word_t exp_codes   = '0;

    datapath_core datapath_core_i (
        .clk                   (clk),
        .reset_i               (reset_i),
        .cfg_i                 (cfg_i),
        .adc_codes_i           (adc_codes_i),
        .sd_flags_o            (sd_flags_o),
        .sliced_bits_o         (sliced_bits_o),
        .res_errors_o          (res_errors_o),
        .aligned_sliced_bits_o (aligned_sliced_bits_o)
    );

    always #2 clk = ~clk;

    function automatic dsp_cfg_t make_cfg(input int w0, input int w1, input int w2,
                                          input int sh, input int h0, input int h1,
                                          input int h2);
        dsp_cfg_t c;
        c.ffe_weights[0] = weight_t'(w0);
        c.ffe_weights[1] = weight_t'(w1);
        c.ffe_weights[2] = weight_t'(w2);
        c.ffe_shift      = sh[`DP_SHIFT_W-1:0];
        c.channel_est[0] = chan_tap_t'(h0);
        c.channel_est[1] = chan_tap_t'(h1);
        c.channel_est[2] = chan_tap_t'(h2);
        return c;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        fail_cnt++;
        $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
        $display("test failed");
        $fatal(1, "stopping at first error");
    endtask

    // reset for RST_CYC edges with the new config, then one word per edge
    task automatic run_phase(input int p);
        @(posedge clk);
        reset_i     <= 1'b1;
        cfg_i       <= phase_cfg[p];
        adc_codes_i <= '0;
        drv_idx     <= -1;
        ph          <= p;
        repeat (RST_CYC - 1) @(posedge clk);
        for (int i = 0; i < N_DRIVE; i++) begin
            @(posedge clk);
            reset_i     <= 1'b0;
            adc_codes_i <= stim_codes[p][i];
            drv_idx     <= i;
        end
    endtask

    // drv_idx trails the driven word by one edge and these registers by one more
    always @(posedge clk) begin
        int fi;
        int oi;
        fi = drv_idx + 1 - FLAG_LAT;
        oi = drv_idx + 1 - OUT_LAT;
        reset_d <= reset_i;
        flags_d <= sd_flags_o;
        flag_en <= (fi >= 0) && (fi < N_CHECK);
        out_en  <= (oi >= 0) && (oi < N_CHECK);
        if (fi >= 0 && fi < N_DRIVE) begin
            exp_flags <= exp_flag_w[ph][fi];
        end
        if (oi >= 0 && oi < N_DRIVE) begin
            exp_bits    <= exp_bit_w[ph][oi];
            exp_aligned <= exp_raw_w[ph][oi];
            exp_res     <= exp_res_w[ph][oi];
            exp_codes   <= widen_codes(stim_codes[ph][oi]);
        end
    end

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= TIMEOUT_CYC) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    reset_clear: assert property (@(posedge clk) reset_d |->
        {sd_flags_o, sliced_bits_o, res_errors_o, aligned_sliced_bits_o} == '0)
        else report_mismatch("outputs during reset", 64'd0,
            64'($sampled({sd_flags_o, sliced_bits_o, res_errors_o, aligned_sliced_bits_o})));

    flags_match: assert property (@(posedge clk) flag_en |-> sd_flags_o == exp_flags)
        else report_mismatch("sd_flags_o", 64'($sampled(exp_flags)),
            64'($sampled(sd_flags_o)));

    bits_match: assert property (@(posedge clk) out_en |-> sliced_bits_o == exp_bits)
        else report_mismatch("sliced_bits_o", 64'($sampled(exp_bits)),
            64'($sampled(sliced_bits_o)));

    res_match: assert property (@(posedge clk) out_en |-> res_errors_o == exp_res)
        else report_mismatch("res_errors_o", 64'($sampled(exp_res)),
            64'($sampled(res_errors_o)));

    aligned_match: assert property (@(posedge clk)
        out_en |-> aligned_sliced_bits_o == exp_aligned)
        else report_mismatch("aligned_sliced_bits_o", 64'($sampled(exp_aligned)),
            64'($sampled(aligned_sliced_bits_o)));

    // corrected bits are the aligned bits with last cycle's flags applied
    flip_match: assert property (@(posedge clk)
        out_en |-> sliced_bits_o == (aligned_sliced_bits_o ^ flags_d))
        else report_mismatch("sliced_bits_o vs aligned xor flags",
            64'($sampled(aligned_sliced_bits_o) ^ $sampled(flags_d)),
            64'($sampled(sliced_bits_o)));

    // zero channel, so residuals are the delayed codes
    code_pass: assert property (@(posedge clk)
        (out_en && ph == 0) |-> res_errors_o == exp_codes)
        else report_mismatch("res_errors_o (codes)", 64'($sampled(exp_codes)),
            64'($sampled(res_errors_o)));

    initial begin
        reset_i     = 1'b1;
        cfg_i       = '0;
        adc_codes_i = '0;
        drv_idx     = -1;
        ph          = 0;
        fail_cnt    = 0;
        lcg_state   = SEED;
        phase_cfg[0] = make_cfg(64, -16, 8, 6, 0, 0, 0);
        phase_cfg[1] = make_cfg(48, -12, 4, 5, 50, 25, -12);
        phase_cfg[2] = make_cfg(96, 20, -24, 7, 70, -30, 15);
        for (int p = 0; p < N_PHASES; p++) begin
            for (int i = 0; i < N_DRIVE; i++) begin
                for (int l = 0; l < `DP_LANES; l++) begin
                    stim_codes[p][i][l] = lcg_code();
                end
            end
            build_model(p, phase_cfg[p]);
        end
        for (int p = 0; p < N_PHASES; p++) begin
            run_phase(p);
        end
        repeat (2) @(posedge clk);
        if (fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
